// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     := tb_dcache
RTL_TOP    := dcache_top
FILELIST   := dcache.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(RTL_TOP)
SIM_FLAGS  := --binary -j 0 --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dcache.f ====
+incdir+tests
src/dcache_pkg.sv
src/cache_array.sv
src/banked_memory.sv
src/cache_ctrl.sv
src/dcache_top.sv
tests/tb_dcache.sv

// ==== src/banked_memory.sv ====
`timescale 1ns/1ns

module banked_memory #(
    parameter int MEM_LATENCY      = 2,
    parameter int BANK_BUSY_CYCLES = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  dcache_pkg::mem_req_t             req,
    output logic [dcache_pkg::NUM_BANKS-1:0] busy,
    output dcache_pkg::word_t                rdata
);
    import dcache_pkg::*;

    localparam int    ROW_W        = ADDR_W - OFFSET_W;   // Word rows per bank
    localparam int    ROWS         = 2**ROW_W;
    localparam int    CNT_W        = $clog2(BANK_BUSY_CYCLES + 1);
    localparam word_t INIT_PATTERN = 16'hA5A5;

    word_t            bank_mem  [NUM_BANKS][ROWS];
    logic [CNT_W-1:0] busy_cnt  [NUM_BANKS];
    word_t            read_pipe [MEM_LATENCY];

    wsel_t            bank_sel;
    logic [ROW_W-1:0] row_sel;
    logic             strobe;

    assign bank_sel = addr_wsel(req.addr);
    assign row_sel  = req.addr[ADDR_W-1:OFFSET_W];
    assign strobe   = req.rd || req.wr;

    // Word address is row * banks + bank, XORed with a fixed pattern
    initial begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < ROWS; r++) begin
                bank_mem[b][r] = word_t'(r * NUM_BANKS + b) ^ INIT_PATTERN;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                busy_cnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (strobe && bank_sel == wsel_t'(b)) begin
                    busy_cnt[b] <= CNT_W'(BANK_BUSY_CYCLES);
                end else if (busy_cnt[b] != '0) begin
                    busy_cnt[b] <= busy_cnt[b] - 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            busy[b] = (busy_cnt[b] != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (req.wr) begin
            bank_mem[bank_sel][row_sel] <= req.wdata;
        end
    end

    // Delay line lets reads to different banks overlap
    always_ff @(posedge clk) begin
        read_pipe[0] <= bank_mem[bank_sel][row_sel];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            read_pipe[i] <= read_pipe[i-1];
        end
    end

    assign rdata = read_pipe[MEM_LATENCY-1];   // Valid MEM_LATENCY cycles after rd

endmodule

// ==== src/cache_array.sv ====
`timescale 1ns/1ns

module cache_array (
    input  logic               clk,
    input  logic               reset,
    input  dcache_pkg::index_t index,
    input  dcache_pkg::tag_t   tag,
    input  dcache_pkg::wsel_t  word,
    input  dcache_pkg::word_t  wdata,
    input  logic               we,
    input  logic               set_dirty,
    output logic               hit,
    output logic               valid,
    output logic               dirty,
    output dcache_pkg::tag_t   tag_stored,
    output dcache_pkg::word_t  rdata
);
    import dcache_pkg::*;

    localparam int LINES = 2**INDEX_W;

    tag_t             tag_mem  [LINES];
    word_t            data_mem [LINES][NUM_BANKS];
    logic [LINES-1:0] valid_bits;
    logic [LINES-1:0] dirty_bits;

    // Status bits, the only state cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= set_dirty;   // Cleared again by each fill word
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]        <= tag;
            data_mem[index][word] <= wdata;
        end
    end

    // Lookup is combinational so a hit can finish in the request cycle
    always_comb begin
        tag_stored = tag_mem[index];
        valid      = valid_bits[index];
        dirty      = dirty_bits[index];
        rdata      = data_mem[index][word];
        hit        = valid && (tag_stored == tag);
    end

endmodule

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ns

module cache_ctrl #(
    parameter int MEM_LATENCY = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    input  dcache_pkg::cpu_req_t             req,
    output dcache_pkg::cpu_rsp_t             rsp,
    output logic                             stall,
    output dcache_pkg::index_t               arr_index,
    output dcache_pkg::tag_t                 arr_tag,
    output dcache_pkg::wsel_t                arr_word,
    output dcache_pkg::word_t                arr_wdata,
    output logic                             arr_we,
    output logic                             arr_set_dirty,
    input  logic                             arr_hit,
    input  logic                             arr_valid,
    input  logic                             arr_dirty,
    input  dcache_pkg::tag_t                 arr_tag_stored,
    input  dcache_pkg::word_t                arr_rdata,
    output dcache_pkg::mem_req_t             mem_req,
    input  logic [dcache_pkg::NUM_BANKS-1:0] mem_busy,
    input  dcache_pkg::word_t                mem_rdata
);
    import dcache_pkg::*;

    localparam int    LAT_W     = $clog2(MEM_LATENCY + 1);
    localparam wsel_t LAST_WORD = wsel_t'(NUM_BANKS - 1);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    wsel_t            word_cnt;          // Word of the line being moved
    wsel_t            word_cnt_next;
    logic [LAT_W-1:0] lat_cnt;           // Cycles since the fill strobe
    logic [LAT_W-1:0] lat_cnt_next;

    tag_t   req_tag;
    index_t req_index;
    wsel_t  req_word;
    logic   req_valid;
    logic   bank_free;
    logic   data_back;
    addr_t  victim_addr;
    addr_t  fill_addr;

    assign req_tag   = addr_tag(req.addr);
    assign req_index = addr_index(req.addr);
    assign req_word  = addr_wsel(req.addr);
    assign req_valid = req.rd || req.wr;

    // Banks are interleaved, so the word counter is also the bank number
    assign bank_free = !mem_busy[word_cnt];
    assign data_back = (lat_cnt == LAT_W'(MEM_LATENCY));

    assign victim_addr = make_addr(arr_tag_stored, req_index, word_cnt);
    assign fill_addr   = make_addr(req_tag, req_index, word_cnt);

    always_comb begin
        state_next    = state;
        word_cnt_next = word_cnt;
        lat_cnt_next  = lat_cnt;

        rsp           = '0;
        rsp.rdata     = arr_rdata;

        arr_index     = req_index;
        arr_tag       = req_tag;
        arr_word      = req_word;
        arr_wdata     = req.wdata;
        arr_we        = 1'b0;
        arr_set_dirty = 1'b0;

        mem_req       = '0;
        mem_req.addr  = fill_addr;
        mem_req.wdata = arr_rdata;       // Victim word during write-back

        case (state)
            st_idle: begin
                if (req_valid) begin
                    if (arr_hit) begin
                        rsp.done      = 1'b1;
                        rsp.hit       = 1'b1;
                        arr_we        = req.wr;      // Write hit lands at this edge
                        arr_set_dirty = req.wr;
                    end else if (arr_valid && arr_dirty) begin
                        word_cnt_next = '0;
                        state_next    = st_writeback;
                    end else begin
                        word_cnt_next = '0;
                        state_next    = st_fill;
                    end
                end
            end

            st_writeback: begin
                arr_word     = word_cnt;
                mem_req.addr = victim_addr;
                if (bank_free) begin
                    mem_req.wr    = 1'b1;
                    word_cnt_next = word_cnt + 1'b1;  // Wraps to word 0 for the fill
                    if (word_cnt == LAST_WORD) begin
                        state_next = st_wb_wait;
                    end
                end
            end

            // Let every victim write retire before the line is read back
            st_wb_wait: begin
                if (mem_busy == '0) begin
                    state_next = st_fill;
                end
            end

            st_fill: begin
                if (bank_free) begin
                    mem_req.rd   = 1'b1;
                    lat_cnt_next = LAT_W'(1);
                    state_next   = st_fill_wait;
                end
            end

            st_fill_wait: begin
                arr_word  = word_cnt;
                arr_wdata = mem_rdata;
                if (data_back) begin
                    arr_we        = 1'b1;        // Clean copy, tag and valid set
                    word_cnt_next = word_cnt + 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        state_next = st_finish;
                    end else begin
                        state_next = st_fill;
                    end
                end else begin
                    lat_cnt_next = lat_cnt + 1'b1;
                end
            end

            st_finish: begin
                rsp.done      = 1'b1;            // Miss completes with hit low
                arr_we        = req.wr;
                arr_set_dirty = req.wr;
                state_next    = st_idle;
            end

            default: begin
                state_next = st_idle;
            end
        endcase
    end

    assign stall = (state != st_idle || req_valid) && !rsp.done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            word_cnt <= '0;
            lat_cnt  <= '0;
        end else begin
            state    <= state_next;
            word_cnt <= word_cnt_next;
            lat_cnt  <= lat_cnt_next;
        end
    end

endmodule

// ==== src/dcache_pkg.sv ====
package dcache_pkg;

    localparam int TAG_W     = 5;
    localparam int INDEX_W   = 8;
    localparam int OFFSET_W  = 3;
    localparam int WORD_W    = 16;
    localparam int ADDR_W    = TAG_W + INDEX_W + OFFSET_W;
    localparam int NUM_BANKS = 4;                    // Also words per line
    localparam int WSEL_W    = $clog2(NUM_BANKS);    // Offset bits 2 to 1

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WSEL_W-1:0]  wsel_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata;
        logic  done;
        logic  hit;
    } cpu_rsp_t;

    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd;
        logic  wr;
    } mem_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_writeback,
        st_wb_wait,
        st_fill,
        st_fill_wait,
        st_finish
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[OFFSET_W +: INDEX_W];
    endfunction

    // Bit 0 of the byte address is ignored
    function automatic wsel_t addr_wsel(addr_t a);
        return a[1 +: WSEL_W];
    endfunction

    function automatic addr_t make_addr(tag_t t, index_t i, wsel_t w);
        return {t, i, w, 1'b0};
    endfunction

endpackage

// ==== src/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
    parameter int MEM_LATENCY      = 2,
    parameter int BANK_BUSY_CYCLES = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  dcache_pkg::cpu_req_t req,
    output dcache_pkg::cpu_rsp_t rsp,
    output logic                 stall
);
    import dcache_pkg::*;

    index_t                arr_index;
    tag_t                  arr_tag;
    wsel_t                 arr_word;
    word_t                 arr_wdata;
    logic                  arr_we;
    logic                  arr_set_dirty;
    logic                  arr_hit;
    logic                  arr_valid;
    logic                  arr_dirty;
    tag_t                  arr_tag_stored;
    word_t                 arr_rdata;
    mem_req_t              mem_req;
    logic [NUM_BANKS-1:0]  mem_busy;
    word_t                 mem_rdata;

    cache_ctrl #(
        .MEM_LATENCY (MEM_LATENCY)
    ) u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .rsp            (rsp),
        .stall          (stall),
        .arr_index      (arr_index),
        .arr_tag        (arr_tag),
        .arr_word       (arr_word),
        .arr_wdata      (arr_wdata),
        .arr_we         (arr_we),
        .arr_set_dirty  (arr_set_dirty),
        .arr_hit        (arr_hit),
        .arr_valid      (arr_valid),
        .arr_dirty      (arr_dirty),
        .arr_tag_stored (arr_tag_stored),
        .arr_rdata      (arr_rdata),
        .mem_req        (mem_req),
        .mem_busy       (mem_busy),
        .mem_rdata      (mem_rdata)
    );

    cache_array u_array (
        .clk        (clk),
        .reset      (reset),
        .index      (arr_index),
        .tag        (arr_tag),
        .word       (arr_word),
        .wdata      (arr_wdata),
        .we         (arr_we),
        .set_dirty  (arr_set_dirty),
        .hit        (arr_hit),
        .valid      (arr_valid),
        .dirty      (arr_dirty),
        .tag_stored (arr_tag_stored),
        .rdata      (arr_rdata)
    );

    banked_memory #(
        .MEM_LATENCY      (MEM_LATENCY),
        .BANK_BUSY_CYCLES (BANK_BUSY_CYCLES)
    ) u_mem (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .busy  (mem_busy),
        .rdata (mem_rdata)
    );

endmodule

// ==== tests/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

logic [31:0]  lfsr = 32'h89ea_3182;
word_t        shadow_mem [int];         // Only words written so far
tag_t         shadow_tag [256];
logic [255:0] shadow_valid = '0;
int           errors = 0;
int           checks = 0;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [15:0] rand_bits(int n);
    logic [15:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        r = {r[14:0], lfsr[0]};
    end
    return r;
endfunction

function automatic addr_t byte_addr(tag_t t, index_t i, wsel_t w);
    return {t, i, w, 1'b0};
endfunction

// Untouched memory holds its word address XOR A5A5
function automatic word_t shadow_word(int waddr);
    if (shadow_mem.exists(waddr)) begin
        return shadow_mem[waddr];
    end
    return word_t'(waddr) ^ 16'hA5A5;
endfunction

function automatic cpu_rsp_t ref_access(addr_t a, logic wr, word_t d);
    cpu_rsp_t r;
    int       waddr;
    tag_t     t;
    index_t   i;
    waddr   = int'(a >> 1);
    t       = a[15:11];
    i       = a[10:3];
    r.done  = 1'b1;
    r.hit   = shadow_valid[i] && (shadow_tag[i] == t);
    if (wr) begin
        shadow_mem[waddr] = d;
    end
    r.rdata = shadow_word(waddr);
    shadow_valid[i] = 1'b1;             // Line now holds this tag
    shadow_tag[i]   = t;
    return r;
endfunction

task automatic check_word(word_t got, word_t want, string what);
    checks++;
    if (got !== want) begin
        errors++;
        $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, got, want);
    end
endtask

task automatic check_flag(logic got, logic want, string what);
    checks++;
    if (got !== want) begin
        errors++;
        $display("[FAIL] %0t ns: %s got %b, expected %b", $time, what, got, want);
    end
endtask

`endif

// ==== tests/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    `include "tb_util.svh"

    localparam int CLK_PERIOD = 40;
    localparam int NUM_REQS   = 319;    // Directed 19 plus 300 random
    localparam int REQ_CYCLES = 40;

    logic     clk   = 1'b0;
    logic     reset = 1'b1;
    cpu_req_t req   = '0;
    cpu_rsp_t rsp;
    logic     stall;

    cpu_rsp_t exp_q [$];
    bit       rd_q [$];
    int       wait_cycles = 0;
    int       test_num = 0;
    int       test_errs = 0;
    int       reqs_sent = 0;
    int       reqs_checked = 0;

    dcache_top #(
        .MEM_LATENCY      (2),
        .BANK_BUSY_CYCLES (4)
    ) dut0 (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rsp   (rsp),
        .stall (stall)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Present one request and hold it until done
    task automatic access(addr_t a, logic wr, word_t d);
        exp_q.push_back(ref_access(a, wr, d));
        rd_q.push_back(!wr);
        reqs_sent++;
        req <= '{addr: a, wdata: d, rd: !wr, wr: wr};
        do @(posedge clk); while (!rsp.done);
    endtask

    task automatic finish_test(string name);
        wait (reqs_checked == reqs_sent);   // Checker sees the last done at the same edge
        test_num++;
        if (errors == test_errs) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_errs);
        end
        test_errs = errors;
    endtask

    always @(posedge clk) begin
        cpu_rsp_t want;
        if (!reset && (req.rd || req.wr)) begin
            if (!rsp.done) begin
                check_flag(stall, 1'b1, "stall while waiting");
                wait_cycles++;
            end else begin
                want = exp_q.pop_front();
                check_flag(rsp.hit, want.hit, $sformatf("hit for %h", req.addr));
                check_flag(stall, 1'b0, "stall with done");
                if (rd_q.pop_front()) begin
                    check_word(rsp.rdata, want.rdata, $sformatf("rdata for %h", req.addr));
                end
                if (want.hit) begin
                    check_flag(logic'(wait_cycles == 0), 1'b1, "hit done in request cycle");
                end
                wait_cycles = 0;
                reqs_checked++;
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (REQ_CYCLES * NUM_REQS + 10));
        $display("Timeout: done never arrived within %0d cycles per request", REQ_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        tag_t   t;
        index_t i;
        wsel_t  w;
        logic   wr;
        word_t  d;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        access(byte_addr(5'd1, 8'd16, 2'd0), 1'b0, 16'h0);   // Cold misses
        access(byte_addr(5'd2, 8'd17, 2'd1), 1'b0, 16'h0);
        access(byte_addr(5'd3, 8'd18, 2'd3), 1'b0, 16'h0);
        access(byte_addr(5'd0, 8'd19, 2'd2), 1'b0, 16'h0);
        finish_test("read miss after reset");

        access(byte_addr(5'd1, 8'd16, 2'd0), 1'b0, 16'h0);
        access(byte_addr(5'd2, 8'd17, 2'd1), 1'b0, 16'h0);
        access(byte_addr(5'd3, 8'd18, 2'd3), 1'b0, 16'h0);
        access(byte_addr(5'd0, 8'd19, 2'd2), 1'b0, 16'h0);
        finish_test("read hit");

        access(byte_addr(5'd1, 8'd16, 2'd2), 1'b1, 16'h1234);
        access(byte_addr(5'd1, 8'd16, 2'd2), 1'b0, 16'h0);
        finish_test("write hit");

        access(byte_addr(5'd4, 8'd20, 2'd1), 1'b1, 16'hBEEF);
        for (int k = 0; k < 4; k++) begin
            access(byte_addr(5'd4, 8'd20, wsel_t'(k)), 1'b0, 16'h0);
        end
        finish_test("write miss allocate");

        access(byte_addr(5'd1, 8'd16, 2'd0), 1'b1, 16'hCAFE);
        access(byte_addr(5'd7, 8'd16, 2'd3), 1'b0, 16'h0);   // Evicts dirty line
        access(byte_addr(5'd1, 8'd16, 2'd2), 1'b0, 16'h0);
        access(byte_addr(5'd1, 8'd16, 2'd0), 1'b0, 16'h0);
        finish_test("dirty eviction");

        for (int n = 0; n < 300; n++) begin
            t  = tag_t'(rand_bits(2));           // Few tags over few indices
            i  = index_t'(8 + rand_bits(2));
            w  = wsel_t'(rand_bits(2));
            wr = rand_bits(1) != 16'h0;
            d  = rand_bits(16);
            access(byte_addr(t, i, w), wr, d);
        end
        finish_test("random mix");

        req <= '0;
        @(posedge clk);
        $display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
